// ==== board_bus_pkg.sv ====
package board_bus_pkg;

    // bus widths
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    // one RAM word, little-endian bytes
    typedef logic [31:0] word_t;

    // load/store access type
    // stores only use the first four codes
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    // RAM region
    // base is aligned to the region size, so the low bits index the words
    localparam addr_t RAM_BASE  = 64'h0000_0000_0000_1000;
    localparam int    RAM_WORDS = 1024;
    localparam int    RAM_AW    = 10;

    // I/O registers, 8 bytes apart
    // keyboard character, read only
    localparam addr_t KEY_ADDR      = 64'h0000_0000_0000_0100;
    // console data port, write only
    localparam addr_t UART_ADDR     = 64'h0000_0000_0000_0108;
    // timer registers, 64-bit read/write
    localparam addr_t MTIME_ADDR    = 64'h0000_0000_0000_0110;
    localparam addr_t MTIMECMP_ADDR = 64'h0000_0000_0000_0118;

    // vector raised by a key press
    localparam logic [3:0] KEY_IRQ_VEC = 4'd1;

endpackage

// ==== slave_bus_if.sv ====
interface slave_bus_if;
    import board_bus_pkg::*;

    // one-cycle request pulse from the controller
    logic     strobe;
    // request fields, held until ack
    logic     write;
    addr_t    addr;
    ls_type_e ls_type;
    data_t    wdata;

    // one-cycle completion from the slave
    logic     ack;
    // read data, valid with ack
    data_t    rdata;

    // bus controller side
    modport ctrl (
        output strobe,
        output write,
        output addr,
        output ls_type,
        output wdata,
        input  ack,
        input  rdata
    );

    // slave side
    modport slave (
        input  strobe,
        input  write,
        input  addr,
        input  ls_type,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

// ==== bus_controller.sv ====
module bus_controller (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  board_bus_pkg::addr_t    bus_address,
    input  board_bus_pkg::data_t    bus_write_data,
    input  board_bus_pkg::ls_type_e bus_ls_type,
    input  logic                    bus_read_enable,
    input  logic                    bus_write_enable,
    output board_bus_pkg::data_t    bus_read_data,
    output logic                    bus_read_done,
    output logic                    bus_write_done,
    slave_bus_if.ctrl               ram_bus,
    slave_bus_if.ctrl               io_bus
);
    import board_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } state_e;

    state_e   state;

    // captured request
    addr_t    req_addr;
    data_t    req_wdata;
    ls_type_e req_type;
    logic     req_write;

    // decoded target, fixed for the whole access
    logic     sel_ram;
    logic     sel_io;

    logic     ram_hit;
    logic     io_hit;
    logic     ack_in;
    data_t    rdata_in;
    logic     unmapped_done;
    logic     slave_done;
    logic     complete;

    // address decode, only done here
    assign ram_hit = (bus_address >= RAM_BASE) &&
                     (bus_address < RAM_BASE + addr_t'(RAM_WORDS) * 4);
    assign io_hit  = (bus_address == KEY_ADDR)   || (bus_address == UART_ADDR) ||
                     (bus_address == MTIME_ADDR) || (bus_address == MTIMECMP_ADDR);

    // both slaves see the same request fields
    assign ram_bus.addr    = req_addr;
    assign ram_bus.write   = req_write;
    assign ram_bus.ls_type = req_type;
    assign ram_bus.wdata   = req_wdata;
    assign io_bus.addr     = req_addr;
    assign io_bus.write    = req_write;
    assign io_bus.ls_type  = req_type;
    assign io_bus.wdata    = req_wdata;

    // answer from the selected slave
    assign ack_in   = sel_ram ? ram_bus.ack   : io_bus.ack;
    assign rdata_in = sel_ram ? ram_bus.rdata : io_bus.rdata;

    // nothing selected: finish one edge after the enable
    assign unmapped_done = (state == ST_ISSUE) && !sel_ram && !sel_io;
    assign slave_done    = (state == ST_WAIT) && ack_in;
    assign complete      = unmapped_done || slave_done;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= ST_IDLE;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            sel_ram        <= 1'b0;
            sel_io         <= 1'b0;
            ram_bus.strobe <= 1'b0;
            io_bus.strobe  <= 1'b0;
        end else begin
            // strobes are single pulses
            ram_bus.strobe <= 1'b0;
            io_bus.strobe  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (bus_read_enable || bus_write_enable) begin
                        sel_ram <= ram_hit;
                        sel_io  <= io_hit;
                        state   <= ST_ISSUE;
                        // done drops on the enable edge
                        if (bus_read_enable) begin
                            bus_read_done <= 1'b0;
                        end else begin
                            bus_write_done <= 1'b0;
                        end
                    end
                end
                ST_ISSUE: begin
                    if (sel_ram) begin
                        ram_bus.strobe <= 1'b1;
                        state          <= ST_WAIT;
                    end else if (sel_io) begin
                        io_bus.strobe <= 1'b1;
                        state         <= ST_WAIT;
                    end
                end
                default: begin
                    // hold until the slave acks
                end
            endcase
            if (complete) begin
                state <= ST_IDLE;
                if (req_write) begin
                    bus_write_done <= 1'b1;
                end else begin
                    bus_read_done <= 1'b1;
                end
            end
        end
    end

    // request capture on the enable edge
    always_ff @(posedge CLOCK_50) begin
        if (state == ST_IDLE && (bus_read_enable || bus_write_enable)) begin
            req_addr  <= bus_address;
            req_wdata <= bus_write_data;
            req_type  <= bus_ls_type;
            req_write <= !bus_read_enable;
        end
    end

    // read data kept until the next read completes
    always_ff @(posedge CLOCK_50) begin
        if (complete && !req_write) begin
            bus_read_data <= unmapped_done ? '0 : rdata_in;
        end
    end

endmodule

// ==== ram_slave.sv ====
module ram_slave (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    slave_bus_if.slave bus
);
    import board_bus_pkg::*;

    // word storage, byte 0 in bits 7:0
    word_t             mem [RAM_WORDS];

    addr_t             offset;
    logic [RAM_AW-1:0] word_idx;
    logic [RAM_AW-1:0] beat_idx;
    logic [1:0]        lane;
    logic              is_dword;
    // second beat of a doubleword
    logic              beat2;
    logic              active;

    logic [3:0]        byte_en;
    word_t             wr_word;
    word_t             rd_word;
    word_t             shifted;
    // low word of a doubleword load
    word_t             hold_lo;
    data_t             load_val;

    // word index and byte lane within the region
    assign offset   = bus.addr - RAM_BASE;
    assign word_idx = offset[RAM_AW+1:2];
    assign lane     = offset[1:0];
    assign is_dword = (bus.ls_type == LS_D);

    // high word of a doubleword sits in the next word
    assign beat_idx = beat2 ? word_idx + 1'b1 : word_idx;
    assign active   = bus.strobe || beat2;

    // store lane steering
    always_comb begin
        case (bus.ls_type)
            LS_B: begin
                byte_en = 4'b0001 << lane;
                wr_word = {4{bus.wdata[7:0]}};
            end
            LS_H: begin
                byte_en = 4'b0011 << lane;
                wr_word = {2{bus.wdata[15:0]}};
            end
            default: begin
                // word, or one half of a doubleword
                byte_en = 4'b1111;
                wr_word = beat2 ? bus.wdata[63:32] : bus.wdata[31:0];
            end
        endcase
    end

    // load lane shift and extension
    assign rd_word = mem[beat_idx];
    assign shifted = rd_word >> {lane, 3'b000};

    always_comb begin
        case (bus.ls_type)
            LS_B:    load_val = {{56{shifted[7]}}, shifted[7:0]};
            LS_H:    load_val = {{48{shifted[15]}}, shifted[15:0]};
            LS_W:    load_val = {{32{shifted[31]}}, shifted};
            LS_BU:   load_val = {56'd0, shifted[7:0]};
            LS_HU:   load_val = {48'd0, shifted[15:0]};
            LS_WU:   load_val = {32'd0, shifted};
            // doubleword, second beat
            default: load_val = {rd_word, hold_lo};
        endcase
    end

    // memory array and read data
    always_ff @(posedge CLOCK_50) begin
        if (active) begin
            if (bus.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (byte_en[b]) begin
                        mem[beat_idx][8*b +: 8] <= wr_word[8*b +: 8];
                    end
                end
            end else begin
                hold_lo   <= rd_word;
                bus.rdata <= load_val;
            end
        end
    end

    // one beat, or two for a doubleword
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat2   <= 1'b0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= 1'b0;
            if (bus.strobe && is_dword) begin
                beat2 <= 1'b1;
            end else if (active) begin
                beat2   <= 1'b0;
                bus.ack <= 1'b1;
            end
        end
    end

endmodule

// ==== io_regs.sv ====
module io_regs (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        key_pressed,
    input  logic [7:0]  ascii,
    input  logic        interrupt_ack,
    output logic [3:0]  interrupt_vector,
    output logic        uart_write_pulse,
    output logic [31:0] uart_write_data,
    slave_bus_if.slave  bus
);
    import board_bus_pkg::*;

    logic [7:0] key_char;
    data_t      mtime;
    data_t      mtimecmp;
    data_t      rd_val;
    // register select from the address offset
    logic [1:0] reg_sel;
    logic       wr_strobe;

    assign reg_sel   = bus.addr[4:3];
    assign wr_strobe = bus.strobe && bus.write;

    // read mux
    always_comb begin
        case (reg_sel)
            KEY_ADDR[4:3]:   rd_val = {56'd0, key_char};
            MTIME_ADDR[4:3]: rd_val = mtime;
            MTIMECMP_ADDR[4:3]: rd_val = mtimecmp;
            // console port reads as zero
            default:         rd_val = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus.ack          <= 1'b0;
            uart_write_pulse <= 1'b0;
            interrupt_vector <= '0;
            key_char         <= '0;
            mtime            <= '0;
            mtimecmp         <= '0;
        end else begin
            // every access answers on the next edge
            bus.ack          <= bus.strobe;
            // console pulse lines up with the ack
            uart_write_pulse <= wr_strobe && (reg_sel == UART_ADDR[4:3]);
            if (wr_strobe && reg_sel == MTIME_ADDR[4:3]) begin
                mtime <= bus.wdata;
            end
            if (wr_strobe && reg_sel == MTIMECMP_ADDR[4:3]) begin
                mtimecmp <= bus.wdata;
            end
            // last key seen
            if (key_pressed) begin
                key_char <= ascii;
            end
            // keyboard irq, ack wins over a new key
            if (key_pressed && ascii != 8'd0) begin
                interrupt_vector <= KEY_IRQ_VEC;
            end
            if (interrupt_vector != 4'd0 && interrupt_ack) begin
                interrupt_vector <= '0;
            end
        end
    end

    // read data and console character
    always_ff @(posedge CLOCK_50) begin
        if (bus.strobe && !bus.write) begin
            bus.rdata <= rd_val;
        end
        if (wr_strobe && reg_sel == UART_ADDR[4:3]) begin
            uart_write_data <= bus.wdata[31:0];
        end
    end

endmodule

// ==== board_bus_top.sv ====
module board_bus_top (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  board_bus_pkg::addr_t    bus_address,
    input  board_bus_pkg::data_t    bus_write_data,
    input  board_bus_pkg::ls_type_e bus_ls_type,
    input  logic                    bus_read_enable,
    input  logic                    bus_write_enable,
    input  logic                    key_pressed,
    input  logic [7:0]              ascii,
    input  logic                    interrupt_ack,
    output board_bus_pkg::data_t    bus_read_data,
    output logic                    bus_read_done,
    output logic                    bus_write_done,
    output logic [3:0]              interrupt_vector,
    output logic                    uart_write_pulse,
    output logic [31:0]             uart_write_data
);

    // one link per slave
    slave_bus_if ram_bus ();
    slave_bus_if io_bus ();

    // cpu-side handshake, decode and routing
    bus_controller u_bus_controller (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_bus          (ram_bus),
        .io_bus           (io_bus)
    );

    // word RAM
    ram_slave u_ram_slave (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (ram_bus)
    );

    // keyboard, console, timer registers
    io_regs u_io_regs (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_pressed      (key_pressed),
        .ascii            (ascii),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector),
        .uart_write_pulse (uart_write_pulse),
        .uart_write_data  (uart_write_data),
        .bus              (io_bus)
    );

endmodule

// ==== tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// RAM mirror, one word per entry, byte 0 in the low bits
word_t      model_mem [RAM_WORDS];
// io register mirror
data_t      model_mtime;
data_t      model_mtimecmp;
logic [7:0] model_key;

// bytes moved by one access
function automatic int access_size(ls_type_e t);
    case (t)
        LS_B, LS_BU: return 1;
        LS_H, LS_HU: return 2;
        LS_W, LS_WU: return 4;
        default:     return 8;
    endcase
endfunction

// fill value, mixes every address bit
function automatic word_t fill_word(addr_t a);
    return {a[15:0] ^ a[47:32] ^ 16'hc3a5, ~a[15:0] ^ a[31:16] ^ a[63:48]};
endfunction

// byte-wise store, little-endian
function automatic void model_store(addr_t a, data_t d, ls_type_e t);
    addr_t off;
    int    i;
    for (i = 0; i < access_size(t); i++) begin
        off = a + addr_t'(i) - RAM_BASE;
        model_mem[off[RAM_AW+1:2]][8*off[1:0] +: 8] = d[8*i +: 8];
    end
endfunction

// signed types extend the top bit, the rest stay zero-filled
function automatic data_t extend_load(data_t raw, ls_type_e t);
    case (t)
        LS_B:    return data_t'(signed'(raw[7:0]));
        LS_H:    return data_t'(signed'(raw[15:0]));
        LS_W:    return data_t'(signed'(raw[31:0]));
        default: return raw;
    endcase
endfunction

// gather bytes low first, then extend
function automatic data_t model_load(addr_t a, ls_type_e t);
    data_t raw;
    addr_t off;
    int    i;
    raw = '0;
    for (i = 0; i < access_size(t); i++) begin
        off = a + addr_t'(i) - RAM_BASE;
        raw[8*i +: 8] = model_mem[off[RAM_AW+1:2]][8*off[1:0] +: 8];
    end
    return extend_load(raw, t);
endfunction

`endif

// ==== tb_board_bus.sv ====
module tb_board_bus;
    timeunit 1ns;
    timeprecision 1ps;
    import board_bus_pkg::*;

    // roughly 4000 cycles of traffic, limit keeps a wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    // random RAM traffic stays in the low 64 words
    localparam int WINDOW_WORDS   = 64;
    localparam int RAND_OPS       = 300;
    // 0x2000 and 0x2010 alias RAM words if decoded wrongly
    localparam addr_t UNMAPPED [5] = '{64'h0, 64'h104, 64'hfff, 64'h2000, 64'h2010};

    logic        CLOCK_50;
    logic        KEY0;
    addr_t       bus_address;
    data_t       bus_write_data;
    ls_type_e    bus_ls_type;
    logic        bus_read_enable;
    logic        bus_write_enable;
    logic        key_pressed;
    logic [7:0]  ascii;
    logic        interrupt_ack;
    data_t       bus_read_data;
    logic        bus_read_done;
    logic        bus_write_done;
    logic [3:0]  interrupt_vector;
    logic        uart_write_pulse;
    logic [31:0] uart_write_data;

    int          seed = 32'h2082cb58;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    // console monitor results
    int          uart_pulses = 0;
    logic [31:0] uart_last = '0;
    logic        uart_early = 1'b0;

    `include "tb_ref_model.svh"

    board_bus_top u_dut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .key_pressed      (key_pressed),
        .ascii            (ascii),
        .interrupt_ack    (interrupt_ack),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .interrupt_vector (interrupt_vector),
        .uart_write_pulse (uart_write_pulse),
        .uart_write_data  (uart_write_data)
    );

    // 10 ns clock
    initial CLOCK_50 = 1'b0;
    always #5 CLOCK_50 = ~CLOCK_50;

    // run limit
    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: a done flag never rose within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // console pulses, sampled mid-cycle
    always @(negedge CLOCK_50) begin
        if (uart_write_pulse) begin
            uart_pulses = uart_pulses + 1;
            uart_last   = uart_write_data;
            // write must still be in flight
            uart_early  = !bus_write_done;
        end
    end

    task automatic compare_value(data_t actual, data_t expected, string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // one-cycle enable, then wait for done
    task automatic bus_write(addr_t a, data_t d, ls_type_e t);
        bus_address      = a;
        bus_write_data   = d;
        bus_ls_type      = t;
        bus_write_enable = 1'b1;
        @(posedge CLOCK_50);
        #1;
        bus_write_enable = 1'b0;
        compare_value(data_t'(bus_write_done), 64'd0, "write done did not drop");
        while (!bus_write_done) begin
            @(posedge CLOCK_50);
            #1;
        end
    endtask

    task automatic bus_read(addr_t a, ls_type_e t, output data_t d);
        bus_address     = a;
        bus_ls_type     = t;
        bus_read_enable = 1'b1;
        @(posedge CLOCK_50);
        #1;
        bus_read_enable = 1'b0;
        compare_value(data_t'(bus_read_done), 64'd0, "read done did not drop");
        while (!bus_read_done) begin
            @(posedge CLOCK_50);
            #1;
        end
        d = bus_read_data;
    endtask

    task automatic check_read(addr_t a, ls_type_e t, data_t expected, string msg);
        data_t d;
        bus_read(a, t, d);
        compare_value(d, expected, $sformatf("%s (%s at %h)", msg, t.name(), a));
    endtask

    // decoded key, one cycle
    task automatic press_key(logic [7:0] c);
        ascii       = c;
        key_pressed = 1'b1;
        @(posedge CLOCK_50);
        #1;
        key_pressed = 1'b0;
    endtask

    task automatic pulse_irq_ack();
        interrupt_ack = 1'b1;
        @(posedge CLOCK_50);
        #1;
        interrupt_ack = 1'b0;
    endtask

    // aligned to the access size, inside the window
    function automatic addr_t rand_ram_addr(ls_type_e t);
        logic [31:0] r;
        r = $random(seed);
        return RAM_BASE + addr_t'(r[7:0] & ~8'(access_size(t) - 1));
    endfunction

    function automatic ls_type_e rand_load_type();
        logic [31:0] r;
        r = $random(seed);
        return ls_type_e'(3'(r[15:0] % 16'd7));
    endfunction

    initial begin
        addr_t       a;
        data_t       wv;
        ls_type_e    t;
        logic [31:0] r;
        logic [7:0]  key;
        int          i;
        int          pulses_before;

        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = LS_B;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        key_pressed      = 1'b0;
        ascii            = '0;
        interrupt_ack    = 1'b0;
        model_mtime      = '0;
        model_mtimecmp   = '0;
        model_key        = '0;
        repeat (3) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        @(posedge CLOCK_50);
        #1;

        // reset state
        compare_value(data_t'(bus_read_done), 64'd1, "read done after reset");
        compare_value(data_t'(bus_write_done), 64'd1, "write done after reset");
        compare_value(data_t'(interrupt_vector), 64'd0, "vector after reset");
        compare_value(data_t'(uart_write_pulse), 64'd0, "uart pulse after reset");
        check_read(MTIME_ADDR, LS_D, 64'd0, "mtime after reset");
        check_read(MTIMECMP_ADDR, LS_D, 64'd0, "mtimecmp after reset");

        // known window contents first
        for (i = 0; i < WINDOW_WORDS; i++) begin
            a = RAM_BASE + addr_t'(4 * i);
            bus_write(a, data_t'(fill_word(a)), LS_W);
            model_store(a, data_t'(fill_word(a)), LS_W);
        end

        // random stores, each followed by a load
        for (i = 0; i < RAND_OPS; i++) begin
            r  = $random(seed);
            t  = ls_type_e'({1'b0, r[1:0]});
            a  = rand_ram_addr(t);
            wv = {$random(seed), $random(seed)};
            bus_write(a, wv, t);
            model_store(a, wv, t);
            t = rand_load_type();
            // reload the same spot or anywhere in the window
            if (r[31]) begin
                a = a & ~(addr_t'(access_size(t)) - 64'd1);
            end else begin
                a = rand_ram_addr(t);
            end
            check_read(a, t, model_load(a, t), "random load");
        end

        // doublewords, low word first
        for (i = 0; i < 8; i++) begin
            a  = rand_ram_addr(LS_D);
            wv = {$random(seed), $random(seed)};
            bus_write(a, wv, LS_D);
            model_store(a, wv, LS_D);
            check_read(a, LS_WU, {32'd0, wv[31:0]}, "dword low word");
            check_read(a + 64'd4, LS_WU, {32'd0, wv[63:32]}, "dword high word");
            check_read(a, LS_D, wv, "dword load");
            check_read(a + 64'd1, LS_B, model_load(a + 64'd1, LS_B), "dword byte");
            check_read(a + 64'd2, LS_HU, model_load(a + 64'd2, LS_HU), "dword half");
            check_read(a + 64'd4, LS_W, model_load(a + 64'd4, LS_W), "dword word");
            check_read(a + 64'd6, LS_H, model_load(a + 64'd6, LS_H), "dword half");
            check_read(a + 64'd7, LS_BU, model_load(a + 64'd7, LS_BU), "dword byte");
        end

        // timer registers and console port
        for (i = 0; i < 4; i++) begin
            model_mtime    = {$random(seed), $random(seed)};
            model_mtimecmp = {$random(seed), $random(seed)};
            bus_write(MTIME_ADDR, model_mtime, LS_D);
            bus_write(MTIMECMP_ADDR, model_mtimecmp, LS_D);
            check_read(MTIME_ADDR, LS_D, model_mtime, "mtime readback");
            check_read(MTIMECMP_ADDR, LS_D, model_mtimecmp, "mtimecmp readback");
            wv            = {$random(seed), $random(seed)};
            pulses_before = uart_pulses;
            bus_write(UART_ADDR, wv, LS_W);
            compare_value(data_t'(uart_pulses - pulses_before), 64'd1, "uart pulse count");
            compare_value(data_t'(uart_last), {32'd0, wv[31:0]}, "uart data");
            compare_value(data_t'(uart_early), 64'd1, "uart pulse before write done");
        end

        // keyboard interrupt
        for (i = 0; i < 4; i++) begin
            r   = $random(seed);
            key = (r[7:0] == 8'd0) ? 8'h41 : r[7:0];
            press_key(key);
            model_key = key;
            compare_value(data_t'(interrupt_vector), 64'd1, "vector after key");
            check_read(KEY_ADDR, LS_D, {56'd0, model_key}, "key character");
            pulse_irq_ack();
            compare_value(data_t'(interrupt_vector), 64'd0, "vector after ack");
        end
        // zero character, no interrupt
        press_key(8'd0);
        model_key = 8'd0;
        compare_value(data_t'(interrupt_vector), 64'd0, "vector after zero key");
        check_read(KEY_ADDR, LS_D, {56'd0, model_key}, "zero key character");

        // unmapped reads return zero even after other data
        check_read(RAM_BASE, LS_WU, model_load(RAM_BASE, LS_WU), "ram word 0");
        for (i = 0; i < 5; i++) begin
            check_read(UNMAPPED[i], LS_D, 64'd0, "unmapped read");
        end
        for (i = 0; i < 5; i++) begin
            bus_write(UNMAPPED[i], {$random(seed), $random(seed)}, LS_W);
        end
        // window untouched
        for (i = 0; i < WINDOW_WORDS; i++) begin
            a = RAM_BASE + addr_t'(4 * i);
            check_read(a, LS_WU, model_load(a, LS_WU), "ram after unmapped writes");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
board_bus_pkg.sv
slave_bus_if.sv
bus_controller.sv
ram_slave.sv
io_regs.sv
board_bus_top.sv
tb_board_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the board bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module tb_board_bus -Mdir obj_dir -o tb_board_bus
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_board_bus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict comes from the log
if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
